// File: verilog.f
trap_code_pkg.sv
trap_arch_pkg.sv
trap_capture.sv
trap_arbiter.sv
trap_vector_gen.sv
exception_handler.sv
tb_exception_handler.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the trap decision unit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
    --top-module tb_exception_handler \
    -f verilog.f \
    -o sim_tb

# The simulator exits non-zero on a fatal check, the log decides
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "test passed" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

// File: tb_exception_handler.sv
// Testbench for the trap decision unit with directed tests and a reference model of the rules
`timescale 1ns/1ps

module tb_exception_handler;

    localparam int unsigned NS      = 4;
    localparam int unsigned CW      = trap_code_pkg::CAUSE_W;
    localparam int unsigned PW      = trap_code_pkg::PRIO_W;
    localparam int unsigned XL      = trap_arch_pkg::XLEN;
    localparam int          TIMEOUT = 10;

    logic                      clk_i;
    logic                      rst_ni;
    logic [NS-1:0]             stage_valid_i;
    logic [NS-1:0][CW-1:0]     stage_cause_i;
    logic [NS-1:0][PW-1:0]     stage_prio_i;
    logic [NS-1:0][XL-1:0]     stage_pc_i;
    logic [NS-1:0][XL-1:0]     stage_tval_i;
    logic                      mstatus_mie_i;
    logic                      mie_msie_i;
    logic                      mie_mtie_i;
    logic                      mie_meie_i;
    logic                      mip_msip_i;
    logic                      mip_mtip_i;
    logic                      mip_meip_i;
    logic [XL-1:0]             mtvec_base_i;
    logic [1:0]                mtvec_mode_i;
    logic                      trap_valid_o;
    logic                      trap_is_irq_o;
    logic [CW-1:0]             trap_cause_o;
    logic [XL-1:0]             trap_pc_o;
    logic [XL-1:0]             trap_tval_o;
    logic [XL-1:0]             trap_vector_o;

    // Stimulus for the next input cycle, bit order {ext, timer, soft}
    logic [NS-1:0]             d_valid;
    logic [NS-1:0][CW-1:0]     d_cause;
    logic [NS-1:0][PW-1:0]     d_prio;
    logic [NS-1:0][XL-1:0]     d_pc;
    logic [NS-1:0][XL-1:0]     d_tval;
    logic                      d_mie;
    logic [2:0]                d_en;
    logic [2:0]                d_pend;
    logic [XL-1:0]             d_base;
    logic [1:0]                d_mode;

    // Expected traps, up to three in flight
    logic                      e_valid [0:2];
    logic                      e_irq   [0:2];
    logic [CW-1:0]             e_cause [0:2];
    logic [XL-1:0]             e_pc    [0:2];
    logic [XL-1:0]             e_tval  [0:2];
    logic [XL-1:0]             e_vec   [0:2];

    logic [31:0]               rng;

    exception_handler #(
        .N_STAGES (NS)
    ) dut_i (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .stage_valid_i (stage_valid_i),
        .stage_cause_i (stage_cause_i),
        .stage_prio_i  (stage_prio_i),
        .stage_pc_i    (stage_pc_i),
        .stage_tval_i  (stage_tval_i),
        .mstatus_mie_i (mstatus_mie_i),
        .mie_msie_i    (mie_msie_i),
        .mie_mtie_i    (mie_mtie_i),
        .mie_meie_i    (mie_meie_i),
        .mip_msip_i    (mip_msip_i),
        .mip_mtip_i    (mip_mtip_i),
        .mip_meip_i    (mip_meip_i),
        .mtvec_base_i  (mtvec_base_i),
        .mtvec_mode_i  (mtvec_mode_i),
        .trap_valid_o  (trap_valid_o),
        .trap_is_irq_o (trap_is_irq_o),
        .trap_cause_o  (trap_cause_o),
        .trap_pc_o     (trap_pc_o),
        .trap_tval_o   (trap_tval_o),
        .trap_vector_o (trap_vector_o)
    );

    // 20 ns clock
    always #10 clk_i = ~clk_i;

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        rng = xorshift32(rng);
        r   = rng;
    endtask

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("error: %s got 0x%08h expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic clear_drive();
        d_valid = '0;
        d_mie   = 1'b0;
        d_en    = 3'b000;
        d_pend  = 3'b000;
    endtask

    // Random payload on every stage, valid only where mask is set
    // pmask narrows the priorities so that ties show up
    task automatic fill_stages(input logic [NS-1:0] mask, input logic [PW-1:0] pmask);
        logic [31:0] r;
        d_valid = mask;
        for (int s = 0; s < NS; s++) begin
            next_rand(r);
            d_cause[s] = r[3:0];
            d_prio[s]  = r[7:4] & pmask;
            next_rand(r);
            d_pc[s] = r;
            next_rand(r);
            d_tval[s] = r;
        end
    endtask

    // Reference model of the selection and vector rules
    task automatic predict(input int k);
        int         best;
        logic [2:0] act;
        best = -1;
        act  = d_pend & d_en & {3{d_mie}};
        for (int s = 0; s < NS; s++) begin
            if (d_valid[s] && (best < 0 || d_prio[s] < d_prio[best])) begin
                best = s;
            end
        end
        e_valid[k] = (act != 3'b000) || (best >= 0);
        e_irq[k]   = (act != 3'b000);
        e_cause[k] = '0;
        e_pc[k]    = '0;
        e_tval[k]  = '0;
        if (act[2]) begin
            e_cause[k] = trap_code_pkg::CAUSE_M_EXT;
        end else if (act[1]) begin
            e_cause[k] = trap_code_pkg::CAUSE_M_TIMER;
        end else if (act[0]) begin
            e_cause[k] = trap_code_pkg::CAUSE_M_SOFT;
        end else if (best >= 0) begin
            e_cause[k] = d_cause[best];
            e_pc[k]    = d_pc[best];
            e_tval[k]  = d_tval[best];
        end
        e_vec[k] = '0;
        if (e_valid[k]) begin
            e_vec[k] = d_base & ~32'h3;
            // Table entry only for interrupts in vectored mode
            if (e_irq[k] && d_mode == trap_arch_pkg::MTVEC_VECTORED) begin
                e_vec[k] = e_vec[k] + 32'(e_cause[k]) * 32'd4;
            end
        end
    endtask

    task automatic apply_inputs();
        stage_valid_i <= d_valid;
        stage_cause_i <= d_cause;
        stage_prio_i  <= d_prio;
        stage_pc_i    <= d_pc;
        stage_tval_i  <= d_tval;
        mstatus_mie_i <= d_mie;
        mie_meie_i    <= d_en[2];
        mie_mtie_i    <= d_en[1];
        mie_msie_i    <= d_en[0];
        mip_meip_i    <= d_pend[2];
        mip_mtip_i    <= d_pend[1];
        mip_msip_i    <= d_pend[0];
        mtvec_base_i  <= d_base;
        mtvec_mode_i  <= d_mode;
    endtask

    // mtvec is left alone, the vector stage still samples it
    task automatic drive_idle();
        stage_valid_i <= '0;
        mip_meip_i    <= 1'b0;
        mip_mtip_i    <= 1'b0;
        mip_msip_i    <= 1'b0;
    endtask

    task automatic check_trap(input int k);
        check_value("trap_valid_o", 32'(trap_valid_o), 32'(e_valid[k]));
        check_value("trap_is_irq_o", 32'(trap_is_irq_o), 32'(e_irq[k]));
        check_value("trap_cause_o", 32'(trap_cause_o), 32'(e_cause[k]));
        check_value("trap_pc_o", trap_pc_o, e_pc[k]);
        check_value("trap_tval_o", trap_tval_o, e_tval[k]);
        check_value("trap_vector_o", trap_vector_o, e_vec[k]);
    endtask

    // One input cycle, then wait for the trap or two edges when none is due
    task automatic run_one();
        int   n;
        logic done;
        @(posedge clk_i);
        predict(0);
        apply_inputs();
        n    = 0;
        done = 1'b0;
        while (!done) begin
            @(posedge clk_i);
            if (n == 0) begin
                drive_idle();
            end
            n++;
            @(negedge clk_i);
            if (e_valid[0] ? trap_valid_o : (n == 2)) begin
                done = 1'b1;
            end else if (n >= TIMEOUT) begin
                fail_run("timeout while waiting for trap_valid_o");
            end
        end
        check_value("latency", 32'(n), 32'd2);
        check_trap(0);
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------

    task automatic test_reset_idle();
        clear_drive();
        d_base = 32'h0000_1000;
        d_mode = trap_arch_pkg::MTVEC_DIRECT;
        for (int i = 0; i < 3; i++) begin
            run_one();
        end
    endtask

    task automatic test_single_exception();
        logic [31:0] r;
        next_rand(r);
        d_base = r;
        d_mode = trap_arch_pkg::MTVEC_DIRECT;
        for (int i = 0; i < 8; i++) begin
            clear_drive();
            next_rand(r);
            fill_stages(4'b0001 << r[1:0], 4'hF);
            run_one();
        end
    endtask

    task automatic test_priority();
        logic [31:0] r;
        for (int i = 0; i < 24; i++) begin
            clear_drive();
            next_rand(r);
            fill_stages(r[3:0], (i % 2 == 0) ? 4'h3 : 4'hF);
            run_one();
        end
    endtask

    task automatic test_interrupts();
        clear_drive();
        fill_stages(4'b0000, 4'hF);
        // Masked by own enable, then by global enable
        d_mie  = 1'b1;
        d_pend = 3'b111;
        run_one();
        d_mie = 1'b0;
        d_en  = 3'b111;
        run_one();
        // Fixed order
        d_mie = 1'b1;
        run_one();
        d_pend = 3'b011;
        run_one();
        d_pend = 3'b001;
        run_one();
        d_pend = 3'b010;
        d_en   = 3'b101;
        run_one();
        // Beats all stage reports
        fill_stages(4'b1111, 4'hF);
        d_pend = 3'b001;
        d_en   = 3'b111;
        run_one();
    endtask

    task automatic test_vectored();
        logic [31:0] r;
        next_rand(r);
        d_base = r | 32'h3;
        for (int m = 0; m < 4; m++) begin
            d_mode = 2'(m);
            for (int src = 0; src < 3; src++) begin
                clear_drive();
                d_mie  = 1'b1;
                d_en   = 3'b111;
                d_pend = 3'b001 << src;
                run_one();
            end
            clear_drive();
            fill_stages(4'b0100, 4'hF);
            run_one();
        end
    endtask

    // Three input sets back to back, outputs follow two cycles behind
    task automatic test_back_to_back();
        logic [31:0] r;
        next_rand(r);
        d_base = r;
        d_mode = trap_arch_pkg::MTVEC_VECTORED;
        for (int c = 0; c < 5; c++) begin
            @(posedge clk_i);
            clear_drive();
            if (c == 0) begin
                fill_stages(4'b0010, 4'hF);
            end else if (c == 1) begin
                d_mie  = 1'b1;
                d_en   = 3'b111;
                d_pend = 3'b010;
            end else if (c == 2) begin
                fill_stages(4'b1011, 4'h1);
            end
            if (c < 3) begin
                predict(c);
                apply_inputs();
            end else if (c == 3) begin
                drive_idle();
            end
            @(negedge clk_i);
            if (c < 2) begin
                check_value("trap_valid_o", 32'(trap_valid_o), 32'd0);
            end else begin
                check_trap(c - 2);
            end
        end
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial begin
        clk_i  = 1'b0;
        rst_ni = 1'b0;
        rng    = 32'd928;
        d_base = '0;
        d_mode = '0;
        clear_drive();
        fill_stages(4'b0000, 4'hF);
        stage_valid_i = '0;
        stage_cause_i = '0;
        stage_prio_i  = '0;
        stage_pc_i    = '0;
        stage_tval_i  = '0;
        mstatus_mie_i = 1'b0;
        mie_msie_i    = 1'b0;
        mie_mtie_i    = 1'b0;
        mie_meie_i    = 1'b0;
        mip_msip_i    = 1'b0;
        mip_mtip_i    = 1'b0;
        mip_meip_i    = 1'b0;
        mtvec_base_i  = '0;
        mtvec_mode_i  = '0;
        repeat (10) @(posedge clk_i);
        rst_ni <= 1'b1;
        test_reset_idle();
        test_single_exception();
        test_priority();
        test_interrupts();
        test_vectored();
        test_back_to_back();
        $display("test passed");
        $finish;
    end

endmodule : tb_exception_handler

// File: exception_handler.sv
// Trap decision unit top that chains capture, arbitration and vector generation
`timescale 1ns/1ps

module exception_handler #(
    // Fetch, execute, memory, writeback
    parameter int unsigned N_STAGES = 4
) (
    input  logic clk_i,
    input  logic rst_ni,

    // Exception reports from the pipeline, indexed by stage
    input  logic [N_STAGES-1:0]                              stage_valid_i,
    input  logic [N_STAGES-1:0][trap_code_pkg::CAUSE_W-1:0]  stage_cause_i,
    input  logic [N_STAGES-1:0][trap_code_pkg::PRIO_W-1:0]   stage_prio_i,
    input  logic [N_STAGES-1:0][trap_arch_pkg::XLEN-1:0]     stage_pc_i,
    input  logic [N_STAGES-1:0][trap_arch_pkg::XLEN-1:0]     stage_tval_i,

    // Interrupt enables and pending bits from the CSR block
    input  logic mstatus_mie_i,
    input  logic mie_msie_i,
    input  logic mie_mtie_i,
    input  logic mie_meie_i,
    input  logic mip_msip_i,
    input  logic mip_mtip_i,
    input  logic mip_meip_i,

    // mtvec
    input  logic [trap_arch_pkg::XLEN-1:0] mtvec_base_i,
    input  logic [1:0]                     mtvec_mode_i,

    // Trap result, trap_valid_o also flushes the pipeline
    output logic                              trap_valid_o,
    output logic                              trap_is_irq_o,
    output logic [trap_code_pkg::CAUSE_W-1:0] trap_cause_o,
    output logic [trap_arch_pkg::XLEN-1:0]    trap_pc_o,
    output logic [trap_arch_pkg::XLEN-1:0]    trap_tval_o,
    output logic [trap_arch_pkg::XLEN-1:0]    trap_vector_o
);

    // ----------------------------------------
    // Capture to arbiter
    // ----------------------------------------

    logic [N_STAGES-1:0]                              cap_valid;
    logic [N_STAGES-1:0][trap_code_pkg::CAUSE_W-1:0]  cap_cause;
    logic [N_STAGES-1:0][trap_code_pkg::PRIO_W-1:0]   cap_prio;
    logic [N_STAGES-1:0][trap_arch_pkg::XLEN-1:0]     cap_pc;
    logic [N_STAGES-1:0][trap_arch_pkg::XLEN-1:0]     cap_tval;
    logic                                             cap_irq_valid;
    logic [trap_code_pkg::CAUSE_W-1:0]                cap_irq_cause;

    // ----------------------------------------
    // Arbiter to vector generator
    // ----------------------------------------

    logic                              sel_valid;
    logic                              sel_is_irq;
    logic [trap_code_pkg::CAUSE_W-1:0] sel_cause;
    logic [trap_arch_pkg::XLEN-1:0]    sel_pc;
    logic [trap_arch_pkg::XLEN-1:0]    sel_tval;

    // Cycle 1, mask interrupts and register everything
    trap_capture #(
        .N_STAGES (N_STAGES)
    ) u_capture (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .stage_valid_i   (stage_valid_i),
        .stage_cause_i   (stage_cause_i),
        .stage_prio_i    (stage_prio_i),
        .stage_pc_i      (stage_pc_i),
        .stage_tval_i    (stage_tval_i),
        .mstatus_mie_i   (mstatus_mie_i),
        .mie_msie_i      (mie_msie_i),
        .mie_mtie_i      (mie_mtie_i),
        .mie_meie_i      (mie_meie_i),
        .mip_msip_i      (mip_msip_i),
        .mip_mtip_i      (mip_mtip_i),
        .mip_meip_i      (mip_meip_i),
        .cap_valid_o     (cap_valid),
        .cap_cause_o     (cap_cause),
        .cap_prio_o      (cap_prio),
        .cap_pc_o        (cap_pc),
        .cap_tval_o      (cap_tval),
        .cap_irq_valid_o (cap_irq_valid),
        .cap_irq_cause_o (cap_irq_cause)
    );

    // Same cycle pick of the winner
    trap_arbiter #(
        .N_STAGES (N_STAGES)
    ) u_arbiter (
        .cap_valid_i     (cap_valid),
        .cap_cause_i     (cap_cause),
        .cap_prio_i      (cap_prio),
        .cap_pc_i        (cap_pc),
        .cap_tval_i      (cap_tval),
        .cap_irq_valid_i (cap_irq_valid),
        .cap_irq_cause_i (cap_irq_cause),
        .sel_valid_o     (sel_valid),
        .sel_is_irq_o    (sel_is_irq),
        .sel_cause_o     (sel_cause),
        .sel_pc_o        (sel_pc),
        .sel_tval_o      (sel_tval)
    );

    // Cycle 2, vector address and output registers
    trap_vector_gen u_vector_gen (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .sel_valid_i   (sel_valid),
        .sel_is_irq_i  (sel_is_irq),
        .sel_cause_i   (sel_cause),
        .sel_pc_i      (sel_pc),
        .sel_tval_i    (sel_tval),
        .mtvec_base_i  (mtvec_base_i),
        .mtvec_mode_i  (mtvec_mode_i),
        .trap_valid_o  (trap_valid_o),
        .trap_is_irq_o (trap_is_irq_o),
        .trap_cause_o  (trap_cause_o),
        .trap_pc_o     (trap_pc_o),
        .trap_tval_o   (trap_tval_o),
        .trap_vector_o (trap_vector_o)
    );

endmodule : exception_handler

// File: trap_vector_gen.sv
// Trap vector generator that computes the handler address from mtvec and registers the trap
`timescale 1ns/1ps

module trap_vector_gen (
    input  logic clk_i,
    input  logic rst_ni,

    // Selected trap from the arbiter
    input  logic                              sel_valid_i,
    input  logic                              sel_is_irq_i,
    input  logic [trap_code_pkg::CAUSE_W-1:0] sel_cause_i,
    input  logic [trap_arch_pkg::XLEN-1:0]    sel_pc_i,
    input  logic [trap_arch_pkg::XLEN-1:0]    sel_tval_i,

    // mtvec fields from the CSR block
    input  logic [trap_arch_pkg::XLEN-1:0]    mtvec_base_i,
    input  logic [1:0]                        mtvec_mode_i,

    // Trap to the CSR block and the pipeline
    output logic                              trap_valid_o,
    output logic                              trap_is_irq_o,
    output logic [trap_code_pkg::CAUSE_W-1:0] trap_cause_o,
    output logic [trap_arch_pkg::XLEN-1:0]    trap_pc_o,
    output logic [trap_arch_pkg::XLEN-1:0]    trap_tval_o,
    output logic [trap_arch_pkg::XLEN-1:0]    trap_vector_o
);

    logic [trap_arch_pkg::XLEN-1:0] base_aligned;
    logic [trap_arch_pkg::XLEN-1:0] cause_offset;
    logic [trap_arch_pkg::XLEN-1:0] vector_d;

    // ----------------------------------------
    // Vector address
    // ----------------------------------------

    // Drop the MODE bits from BASE
    assign base_aligned = {mtvec_base_i[trap_arch_pkg::XLEN-1:trap_arch_pkg::VEC_ALIGN_BITS],
                           {trap_arch_pkg::VEC_ALIGN_BITS{1'b0}}};

    // Four bytes per table entry
    assign cause_offset = {{(trap_arch_pkg::XLEN - trap_code_pkg::CAUSE_W
                             - trap_arch_pkg::VEC_ALIGN_BITS){1'b0}},
                           sel_cause_i,
                           {trap_arch_pkg::VEC_ALIGN_BITS{1'b0}}};

    // Only interrupts use the table, exceptions always land on BASE
    always_comb begin
        vector_d = '0;
        if (sel_valid_i) begin
            if (sel_is_irq_i && (mtvec_mode_i == trap_arch_pkg::MTVEC_VECTORED)) begin
                vector_d = base_aligned + cause_offset;
            end else begin
                vector_d = base_aligned;
            end
        end
    end

    // ----------------------------------------
    // Output registers
    // ----------------------------------------

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            trap_valid_o  <= 1'b0;
            trap_is_irq_o <= 1'b0;
            trap_cause_o  <= '0;
            trap_pc_o     <= '0;
            trap_tval_o   <= '0;
            trap_vector_o <= '0;
        end else begin
            trap_valid_o  <= sel_valid_i;
            trap_is_irq_o <= sel_is_irq_i;
            trap_cause_o  <= sel_cause_i;
            trap_pc_o     <= sel_pc_i;
            trap_tval_o   <= sel_tval_i;
            trap_vector_o <= vector_d;
        end
    end

endmodule : trap_vector_gen

// File: trap_arbiter.sv
// Trap arbiter that picks one winning trap from the captured interrupt and stage reports
`timescale 1ns/1ps

module trap_arbiter #(
    parameter int unsigned N_STAGES = 4
) (
    // Captured sources
    input  logic [N_STAGES-1:0]                              cap_valid_i,
    input  logic [N_STAGES-1:0][trap_code_pkg::CAUSE_W-1:0]  cap_cause_i,
    input  logic [N_STAGES-1:0][trap_code_pkg::PRIO_W-1:0]   cap_prio_i,
    input  logic [N_STAGES-1:0][trap_arch_pkg::XLEN-1:0]     cap_pc_i,
    input  logic [N_STAGES-1:0][trap_arch_pkg::XLEN-1:0]     cap_tval_i,
    input  logic                                             cap_irq_valid_i,
    input  logic [trap_code_pkg::CAUSE_W-1:0]                cap_irq_cause_i,

    // Selected trap, combinational
    output logic                              sel_valid_o,
    output logic                              sel_is_irq_o,
    output logic [trap_code_pkg::CAUSE_W-1:0] sel_cause_o,
    output logic [trap_arch_pkg::XLEN-1:0]    sel_pc_o,
    output logic [trap_arch_pkg::XLEN-1:0]    sel_tval_o
);

    logic [trap_code_pkg::PRIO_W-1:0]  min_prio;
    logic                              exc_found;
    logic [trap_code_pkg::CAUSE_W-1:0] exc_cause;
    logic [trap_arch_pkg::XLEN-1:0]    exc_pc;
    logic [trap_arch_pkg::XLEN-1:0]    exc_tval;

    // ----------------------------------------
    // Best priority among valid stages
    // ----------------------------------------

    // Invalid stages never lower the minimum, they count as PRIO_NONE
    always_comb begin
        min_prio = trap_code_pkg::PRIO_NONE;
        for (int s = 0; s < N_STAGES; s++) begin
            if (cap_valid_i[s] && (cap_prio_i[s] < min_prio)) begin
                min_prio = cap_prio_i[s];
            end
        end
    end

    // ----------------------------------------
    // Stage pick
    // ----------------------------------------

    // Walk from the top index down so the lowest matching stage is written last
    // A valid stage tagged PRIO_NONE still matches when nothing beats it
    always_comb begin
        exc_found = 1'b0;
        exc_cause = '0;
        exc_pc    = '0;
        exc_tval  = '0;
        for (int s = N_STAGES - 1; s >= 0; s--) begin
            if (cap_valid_i[s] && (cap_prio_i[s] == min_prio)) begin
                exc_found = 1'b1;
                exc_cause = cap_cause_i[s];
                exc_pc    = cap_pc_i[s];
                exc_tval  = cap_tval_i[s];
            end
        end
    end

    // ----------------------------------------
    // Final selection
    // ----------------------------------------

    // Interrupts beat every exception
    // Interrupt has no faulting pc or tval, both go out as zero
    always_comb begin
        sel_valid_o  = 1'b0;
        sel_is_irq_o = 1'b0;
        sel_cause_o  = '0;
        sel_pc_o     = '0;
        sel_tval_o   = '0;
        if (cap_irq_valid_i) begin
            sel_valid_o  = 1'b1;
            sel_is_irq_o = 1'b1;
            sel_cause_o  = cap_irq_cause_i;
        end else if (exc_found) begin
            sel_valid_o  = 1'b1;
            sel_cause_o  = exc_cause;
            sel_pc_o     = exc_pc;
            sel_tval_o   = exc_tval;
        end
    end

endmodule : trap_arbiter

// File: trap_capture.sv
// Trap capture stage that masks and ranks interrupts and registers all stage reports
`timescale 1ns/1ps

module trap_capture #(
    parameter int unsigned N_STAGES = 4
) (
    input  logic clk_i,
    input  logic rst_ni,

    // Exception reports with one element per pipeline stage
    input  logic [N_STAGES-1:0]                              stage_valid_i,
    input  logic [N_STAGES-1:0][trap_code_pkg::CAUSE_W-1:0]  stage_cause_i,
    input  logic [N_STAGES-1:0][trap_code_pkg::PRIO_W-1:0]   stage_prio_i,
    input  logic [N_STAGES-1:0][trap_arch_pkg::XLEN-1:0]     stage_pc_i,
    input  logic [N_STAGES-1:0][trap_arch_pkg::XLEN-1:0]     stage_tval_i,

    // Interrupt state from the CSR block
    input  logic mstatus_mie_i,
    input  logic mie_msie_i,
    input  logic mie_mtie_i,
    input  logic mie_meie_i,
    input  logic mip_msip_i,
    input  logic mip_mtip_i,
    input  logic mip_meip_i,

    // Registered copies for the arbiter
    output logic [N_STAGES-1:0]                              cap_valid_o,
    output logic [N_STAGES-1:0][trap_code_pkg::CAUSE_W-1:0]  cap_cause_o,
    output logic [N_STAGES-1:0][trap_code_pkg::PRIO_W-1:0]   cap_prio_o,
    output logic [N_STAGES-1:0][trap_arch_pkg::XLEN-1:0]     cap_pc_o,
    output logic [N_STAGES-1:0][trap_arch_pkg::XLEN-1:0]     cap_tval_o,
    output logic                                             cap_irq_valid_o,
    output logic [trap_code_pkg::CAUSE_W-1:0]                cap_irq_cause_o
);

    // ----------------------------------------
    // Interrupt masking
    // ----------------------------------------

    logic                              msi_act;
    logic                              mti_act;
    logic                              mei_act;
    logic                              irq_valid;
    logic [trap_code_pkg::CAUSE_W-1:0] irq_cause;

    // A source is live only with pending, own enable and global enable all set
    assign msi_act = mip_msip_i & mie_msie_i & mstatus_mie_i;
    assign mti_act = mip_mtip_i & mie_mtie_i & mstatus_mie_i;
    assign mei_act = mip_meip_i & mie_meie_i & mstatus_mie_i;

    assign irq_valid = msi_act | mti_act | mei_act;

    // External wins over timer and timer wins over software
    always_comb begin
        irq_cause = '0;
        if (mei_act) begin
            irq_cause = trap_code_pkg::CAUSE_M_EXT;
        end else if (mti_act) begin
            irq_cause = trap_code_pkg::CAUSE_M_TIMER;
        end else if (msi_act) begin
            irq_cause = trap_code_pkg::CAUSE_M_SOFT;
        end
    end

    // ----------------------------------------
    // Capture registers
    // ----------------------------------------

    // Valid bits for the stage reports and the interrupt
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cap_valid_o     <= '0;
            cap_irq_valid_o <= 1'b0;
        end else begin
            cap_valid_o     <= stage_valid_i;
            cap_irq_valid_o <= irq_valid;
        end
    end

    // Cause, priority, pc and tval of every stage plus the interrupt cause
    always_ff @(posedge clk_i) begin
        cap_cause_o     <= stage_cause_i;
        cap_prio_o      <= stage_prio_i;
        cap_pc_o        <= stage_pc_i;
        cap_tval_o      <= stage_tval_i;
        cap_irq_cause_o <= irq_cause;
    end

endmodule : trap_capture

// File: trap_arch_pkg.sv
// Architecture package with datapath widths and the mtvec mode encoding
package trap_arch_pkg;

    // ----------------------------------------
    // Datapath
    // ----------------------------------------

    // Register, pc and address width of the RV32 core
    localparam int unsigned XLEN = 32;

    // ----------------------------------------
    // mtvec
    // ----------------------------------------

    // MODE field of mtvec
    // Reserved codes 2 and 3 behave as direct in this core
    localparam logic [1:0] MTVEC_DIRECT   = 2'd0;
    localparam logic [1:0] MTVEC_VECTORED = 2'd1;

    // Low bits of BASE that hold MODE and are forced to zero
    // Also the shift from cause to vector table offset, entries are one word
    localparam int unsigned VEC_ALIGN_BITS = 2;

endpackage : trap_arch_pkg

// File: trap_code_pkg.sv
// Trap code package with the RISC-V cause values and the stage priority encoding
package trap_code_pkg;

    // ----------------------------------------
    // Cause codes
    // ----------------------------------------

    // Width of an mcause code field as carried through the trap path
    localparam int unsigned CAUSE_W = 4;

    // Synchronous exception causes, interrupt bit not included
    localparam logic [CAUSE_W-1:0] CAUSE_INSTR_ACCESS_FAULT = 4'd1;
    localparam logic [CAUSE_W-1:0] CAUSE_ILLEGAL_INSTR      = 4'd2;
    localparam logic [CAUSE_W-1:0] CAUSE_BREAKPOINT         = 4'd3;
    localparam logic [CAUSE_W-1:0] CAUSE_LOAD_MISALIGNED    = 4'd4;
    localparam logic [CAUSE_W-1:0] CAUSE_LOAD_ACCESS_FAULT  = 4'd5;
    localparam logic [CAUSE_W-1:0] CAUSE_STORE_MISALIGNED   = 4'd6;
    localparam logic [CAUSE_W-1:0] CAUSE_STORE_ACCESS_FAULT = 4'd7;
    localparam logic [CAUSE_W-1:0] CAUSE_ECALL_U            = 4'd8;
    localparam logic [CAUSE_W-1:0] CAUSE_ECALL_S            = 4'd9;
    localparam logic [CAUSE_W-1:0] CAUSE_ECALL_M            = 4'd11;

    // Machine level interrupt causes
    // Same numbering as the mip and mie bit positions
    localparam logic [CAUSE_W-1:0] CAUSE_M_SOFT  = 4'd3;
    localparam logic [CAUSE_W-1:0] CAUSE_M_TIMER = 4'd7;
    localparam logic [CAUSE_W-1:0] CAUSE_M_EXT   = 4'd11;

    // ----------------------------------------
    // Stage priority
    // ----------------------------------------

    // Width of the priority tag that each stage attaches to its report
    localparam int unsigned PRIO_W = 4;

    // Lower value means more urgent
    // All ones marks a stage with nothing to report
    localparam logic [PRIO_W-1:0] PRIO_NONE = 4'hF;

endpackage : trap_code_pkg
